/* forget_gate.f */
+incdir+.
forget_gate_pkg.sv
forget_gate_decode.sv
forget_gate_execute.sv
forget_gate_result.sv
forget_gate.sv
forget_gate_tb.sv

/* forget_gate.sv */
/*
  Forget-gate unit top level
  Decode, execute and result stages joined by the op and sum structs
*/

`include "forget_gate_macros.svh"

module forget_gate (
  input  logic                  CLK,
  input  logic                  RST,

  // Input strobes
  input  logic                  bias_enable,
  input  logic                  term_enable,
  input  logic                  last_enable,

  // Bias or weight/operand pair
  input  logic [`FG_DATA_W-1:0] data_in,

  // Gate value, strobe and neuron number
  output logic                  f_out_enable,
  output logic [`FG_OUT_W-1:0]  f_out,
  output logic [`FG_IDX_W-1:0]  f_index
);

  //////////////////////////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////////////////////////

  forget_gate_pkg::fg_op_t  op;
  forget_gate_pkg::fg_sum_t sum;

  // One op per cycle, idle when no strobe
  forget_gate_decode u_decode (
    .CLK         (CLK),
    .RST         (RST),
    .bias_enable (bias_enable),
    .term_enable (term_enable),
    .last_enable (last_enable),
    .data_in     (data_in),
    .op          (op)
  );

  // Multiply and accumulate
  forget_gate_execute u_execute (
    .CLK (CLK),
    .RST (RST),
    .op  (op),
    .sum (sum)
  );

  // Logistic, strobe lands 3 cycles after the last term
  forget_gate_result u_result (
    .CLK          (CLK),
    .RST          (RST),
    .sum          (sum),
    .f_out_enable (f_out_enable),
    .f_out        (f_out),
    .f_index      (f_index)
  );

endmodule

/* forget_gate_decode.sv */
/*
  Decode stage
  Resolves the input strobes and registers one op per cycle
*/

`include "forget_gate_macros.svh"

module forget_gate_decode (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      bias_enable,
  input  logic                      term_enable,
  input  logic                      last_enable,
  input  logic [`FG_DATA_W-1:0]     data_in,
  output forget_gate_pkg::fg_op_t   op
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Next-op classification
  forget_gate_pkg::fg_kind_e kind_d;
  logic                      last_d;

  // Registered op fields
  forget_gate_pkg::fg_kind_e kind_q;
  logic                      last_q;
  forget_gate_pkg::fg_word_u word_q;

  //////////////////////////////////////////////////////////////////////
  // Strobe priority
  //////////////////////////////////////////////////////////////////////

  // Bias beats term when both are up
  // Last only counts together with a term
  always_comb begin
    kind_d = forget_gate_pkg::kind_idle;
    last_d = 1'b0;
    if (bias_enable) begin
      kind_d = forget_gate_pkg::kind_bias;
    end else if (term_enable) begin
      kind_d = forget_gate_pkg::kind_term;
      last_d = last_enable;
    end
  end

  // Control state
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      kind_q <= forget_gate_pkg::kind_idle;
      last_q <= 1'b0;
    end else begin
      kind_q <= kind_d;
      last_q <= last_d;
    end
  end

  // Word goes through untouched, execute picks the view
  always_ff @(posedge CLK) begin
    word_q <= data_in;
  end

  assign op = '{kind: kind_q, last: last_q, word: word_q};

endmodule

/* forget_gate_execute.sv */
/*
  Execute stage
  Q8.8 multiplier, Q16.16 accumulator, one finished sum per neuron
*/

`include "forget_gate_macros.svh"

module forget_gate_execute (
  input  logic                      CLK,
  input  logic                      RST,
  input  forget_gate_pkg::fg_op_t   op,
  output forget_gate_pkg::fg_sum_t  sum
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Q8.8 times Q8.8 gives Q16.16
  logic signed [`FG_DATA_W-1:0] product;

  // Everything widened to accumulator size
  logic signed [`FG_ACC_W-1:0]  product_ext;
  logic signed [`FG_ACC_W-1:0]  bias_ext;
  logic signed [`FG_ACC_W-1:0]  term_total;

  // Running sum of the neuron in progress
  logic signed [`FG_ACC_W-1:0]  acc_q;

  // Finished sum
  logic                         valid_q;
  logic signed [`FG_ACC_W-1:0]  value_q;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Term view of the union
  assign product     = op.word.term.weight * op.word.term.operand;
  assign product_ext = product;

  // Bias view of the union, sign extended
  assign bias_ext    = op.word.bias;

  // Accumulator plus this cycle's product
  assign term_total  = acc_q + product_ext;

  // Accumulator and sum strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (op.kind)
        // A new bias drops any partial sum
        forget_gate_pkg::kind_bias: acc_q <= bias_ext;
        forget_gate_pkg::kind_term: begin
          if (op.last) begin
            // Cleared so the next bias starts clean
            acc_q   <= '0;
            valid_q <= 1'b1;
          end else begin
            acc_q <= term_total;
          end
        end
        default: acc_q <= acc_q;
      endcase
    end
  end

  // Total is held until the next last term
  always_ff @(posedge CLK) begin
    if (op.kind == forget_gate_pkg::kind_term && op.last) begin
      value_q <= term_total;
    end
  end

  assign sum = '{valid: valid_q, value: value_q};

endmodule

/* forget_gate_golden.txt */
// Columns: kind byte _ data word (hex). Kinds 00 idle, 01 bias, 02 term, 03 last term,
// 04 bias with term, 05 last alone, 06 bias without gap, 0e {gate, 00, index}, 0f reset, ff end
01_00000000
03_00000000
0e_0080_00_00
01_00040000
03_01000100
0e_0100_00_01
01_fffc0000
03_0100ff00
0e_0000_00_02
// Mixed-sign terms
01_00008000
02_01800040
02_ff000080
03_0200ffc0
0e_0078_00_03
01_ffff0000
02_ff00ff00
02_0040ff80
02_00330055
03_fff00020
0e_007b_00_04
// Back-to-back neurons
01_00010000
03_01000080
0e_00e0_00_05
06_ffff8000
02_00800080
03_ff800100
0e_0050_00_06
06_00000000
03_01000100
0e_00c0_00_07
// Strobe rules
04_00008000
05_01000100
03_ff000040
0e_0090_00_08
01_00030000
02_01000100
06_ffff4000
03_01000040
0e_0060_00_09
// Reset with a partial neuron in flight
00_00000000
00_00000000
00_00000000
01_00010000
02_01000100
0f_00000000
01_ffff0000
03_00000000
0e_0040_00_00
01_00004000
02_00c00100
03_ff400080
0e_00a8_00_01
ff_00000000

/* forget_gate_macros.svh */
/*
  Fixed widths and Q16.16 constants for the forget-gate unit
  Include guarded, shared by the package and every RTL file
*/

`ifndef FORGET_GATE_MACROS_SVH
`define FORGET_GATE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

// Input data word and each of its halves
`define FG_DATA_W 32
`define FG_HALF_W 16

// Accumulator, Q24.16 so many terms fit without overflow
`define FG_ACC_W 40

// Gate output in Q8.8, 1.0 is 256
`define FG_OUT_W 16

// Fraction bits dropped going from Q16.16 to Q8.8
`define FG_DROP_W 8

// Neuron index, wraps at 256
`define FG_IDX_W 8

// Operation kind encoding
`define FG_KIND_W 2

//////////////////////////////////////////////////////////////////////
// Logistic constants in Q16.16
//////////////////////////////////////////////////////////////////////

`define FG_HALF_Q16 32768
`define FG_ONE_Q16 65536

`endif

/* forget_gate_pkg.sv */
/*
  Shared types of the forget-gate unit
  Data word union, op kind, decode-to-execute and execute-to-result structs
*/

`include "forget_gate_macros.svh"

package forget_gate_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data word
  //////////////////////////////////////////////////////////////////////

  // Term view, weight on top, operand below
  // Both signed Q8.8
  typedef struct packed {
    logic signed [`FG_HALF_W-1:0] weight;
    logic signed [`FG_HALF_W-1:0] operand;
  } fg_term_t;

  // Same 32 bits, read as a Q16.16 bias or as a product pair
  typedef union packed {
    logic signed [`FG_DATA_W-1:0] bias;
    fg_term_t                     term;
  } fg_word_u;

  //////////////////////////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////////////////////////

  // What decode saw this cycle
  typedef enum logic [`FG_KIND_W-1:0] {
    kind_idle = 2'd0,
    kind_bias = 2'd1,
    kind_term = 2'd2
  } fg_kind_e;

  // Decode to execute, 35 bits
  typedef struct packed {
    fg_kind_e kind;
    logic     last;
    fg_word_u word;
  } fg_op_t;

  // Execute to result, 41 bits
  // Valid pulses once per finished neuron
  typedef struct packed {
    logic                        valid;
    logic signed [`FG_ACC_W-1:0] value;
  } fg_sum_t;

endpackage

/* forget_gate_result.sv */
/*
  Result stage
  Hard-sigmoid logistic, Q8.8 output register and neuron index counter
*/

`include "forget_gate_macros.svh"

module forget_gate_result (
  input  logic                      CLK,
  input  logic                      RST,
  input  forget_gate_pkg::fg_sum_t  sum,
  output logic                      f_out_enable,
  output logic [`FG_OUT_W-1:0]      f_out,
  output logic [`FG_IDX_W-1:0]      f_index
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Logistic steps, all Q16.16
  logic signed [`FG_ACC_W-1:0] quarter;
  logic signed [`FG_ACC_W-1:0] shifted;
  logic signed [`FG_ACC_W-1:0] gate_q16;

  // Index for the next output
  logic [`FG_IDX_W-1:0]        next_index;

  //////////////////////////////////////////////////////////////////////
  // Hard sigmoid
  //////////////////////////////////////////////////////////////////////

  // x/4 + 0.5
  assign quarter = sum.value >>> 2;
  assign shifted = quarter + `FG_HALF_Q16;

  // Clamp to 0 .. 1.0
  always_comb begin
    if (shifted < 0) begin
      gate_q16 = '0;
    end else if (shifted > `FG_ONE_Q16) begin
      gate_q16 = `FG_ONE_Q16;
    end else begin
      gate_q16 = shifted;
    end
  end

  // Output register and index counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      f_out_enable <= 1'b0;
      f_out        <= '0;
      f_index      <= '0;
      next_index   <= '0;
    end else begin
      f_out_enable <= sum.valid;
      if (sum.valid) begin
        // Drop 8 fraction bits for Q8.8
        f_out      <= gate_q16[`FG_DROP_W +: `FG_OUT_W];
        f_index    <= next_index;
        // Wraps at 256
        next_index <= next_index + 1'b1;
      end
    end
  end

endmodule

/* forget_gate_tb.sv */
/*
  Testbench for the forget-gate unit
  Replays golden stimulus records, checks gate values, indices and strobe timing
*/

`include "forget_gate_macros.svh"

module forget_gate_tb;

  //////////////////////////////////////////////////////////////////////
  // DUT signals and bookkeeping
  //////////////////////////////////////////////////////////////////////

  logic                  CLK;
  logic                  RST;
  logic                  bias_enable;
  logic                  term_enable;
  logic                  last_enable;
  logic [`FG_DATA_W-1:0] data_in;
  logic                  f_out_enable;
  logic [`FG_OUT_W-1:0]  f_out;
  logic [`FG_IDX_W-1:0]  f_index;

  // Kind byte over a 32-bit data word
  logic [39:0]           golden_mem [0:255];
  int                    n_records;
  logic                  loaded;

  // Expected outputs in order, plus the cycle each strobe is due
  logic [`FG_OUT_W-1:0]  exp_gate_q [$];
  logic [`FG_IDX_W-1:0]  exp_index_q [$];
  int                    due_q [$];
  int                    due_cycle;

  int                    cycle;
  int                    checks;
  int                    value_errors;
  int                    other_errors;
  integer                seed;

  forget_gate dut (
    .CLK          (CLK),
    .RST          (RST),
    .bias_enable  (bias_enable),
    .term_enable  (term_enable),
    .last_enable  (last_enable),
    .data_in      (data_in),
    .f_out_enable (f_out_enable),
    .f_out        (f_out),
    .f_index      (f_index)
  );

  // Period 20
  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  // Edge counter for strobe timing
  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_gate(input logic [`FG_OUT_W-1:0] actual,
                            input logic [`FG_OUT_W-1:0] expected, input string name);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic check_index(input logic [`FG_IDX_W-1:0] actual,
                             input logic [`FG_IDX_W-1:0] expected, input string name);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // One cycle of inputs, driven 2 units after the edge
  task automatic drive_cycle(input logic b, input logic t, input logic l,
                             input logic [`FG_DATA_W-1:0] d);
    bias_enable = b;
    term_enable = t;
    last_enable = l;
    data_in     = d;
    // Last term, strobe due 3 edges on
    if (t && l && !b) begin
      due_q.push_back(cycle + 3);
    end
    @(posedge CLK);
    #2;
  endtask

  // Mid-run reset, outputs and index must clear
  task automatic apply_reset();
    bias_enable = 1'b0;
    term_enable = 1'b0;
    last_enable = 1'b0;
    RST         = 1'b1;
    repeat (3) @(posedge CLK);
    #2;
    check_gate(f_out, '0, "f_out");
    check_index(f_index, '0, "f_index");
    RST = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST && f_out_enable) begin
      if (exp_gate_q.size() == 0) begin
        other_errors++;
        $display("Extra output at %0t: gate %0d index %0d with nothing left to expect",
                 $time, f_out, f_index);
      end else begin
        check_gate(f_out, exp_gate_q.pop_front(), "f_out");
        check_index(f_index, exp_index_q.pop_front(), "f_index");
        if (due_q.size() != 0) begin
          due_cycle = due_q.pop_front();
          checks++;
          if (cycle != due_cycle) begin
            value_errors++;
            $display("Fail at %0t: f_out_enable cycle is %0d, expected %0d",
                     $time, cycle, due_cycle);
          end
        end else begin
          other_errors++;
          $display("Output at %0t arrived with no last term waiting for it", $time);
        end
      end
    end
  end

  // Limit scales with the number of golden records
  initial begin
    wait (loaded);
    #((50 + 4 * n_records) * 20);
    $display("Timeout: the run did not end within %0d cycles", 50 + 4 * n_records);
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                    idx;
    int                    gaps;
    logic [7:0]            kind;
    logic [`FG_DATA_W-1:0] word;
    seed         = 32'h9a5d0e98;
    cycle        = 0;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    loaded       = 1'b0;
    RST          = 1'b1;
    bias_enable  = 1'b0;
    term_enable  = 1'b0;
    last_enable  = 1'b0;
    data_in      = '0;
    $readmemh("forget_gate_golden.txt", golden_mem);
    // End record has kind ff
    n_records = 0;
    while (n_records < 256 && golden_mem[n_records][39:32] !== 8'hff) begin
      n_records++;
    end
    loaded = 1'b1;
    repeat (10) @(posedge CLK);
    #2;
    RST = 1'b0;
    for (idx = 0; idx < n_records; idx++) begin
      kind = golden_mem[idx][39:32];
      word = golden_mem[idx][31:0];
      case (kind)
        8'h00: drive_cycle(1'b0, 1'b0, 1'b0, word);
        // Bias after 0 to 2 random idle cycles
        8'h01: begin
          gaps = {$random(seed)} % 3;
          repeat (gaps) drive_cycle(1'b0, 1'b0, 1'b0, '0);
          drive_cycle(1'b1, 1'b0, 1'b0, word);
        end
        8'h02: drive_cycle(1'b0, 1'b1, 1'b0, word);
        8'h03: drive_cycle(1'b0, 1'b1, 1'b1, word);
        8'h04: drive_cycle(1'b1, 1'b1, 1'b0, word);
        8'h05: drive_cycle(1'b0, 1'b0, 1'b1, word);
        // Bias right after a last term
        8'h06: drive_cycle(1'b1, 1'b0, 1'b0, word);
        8'h0e: begin
          exp_gate_q.push_back(word[31:16]);
          exp_index_q.push_back(word[7:0]);
        end
        8'h0f: apply_reset();
        default: begin
          other_errors++;
          $display("Golden record %0d has an unknown kind %h", idx, kind);
        end
      endcase
    end
    // Let the pipeline drain
    repeat (8) drive_cycle(1'b0, 1'b0, 1'b0, '0);
    if (exp_gate_q.size() != 0) begin
      other_errors++;
      $display("Missing outputs: %0d expected gate values never appeared", exp_gate_q.size());
    end
    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* run_forget_gate.sh */
#!/bin/sh
# Build and run the forget-gate testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module forget_gate_tb \
  -f forget_gate.f --Mdir obj_dir -o forget_gate_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/forget_gate_sim > forget_gate_sim.log 2>&1
status=$?
cat forget_gate_sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" forget_gate_sim.log; then
  exit 0
fi
echo "Pass message not found in forget_gate_sim.log"
exit 1
